//--- verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// architectural word width
`define CPU_XLEN 32

// integer register file size, x0 included
`define CPU_REG_COUNT 32

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// addi x0, x0, 0
// loaded into the decode register on reset and on a flush
`define CPU_NOP 32'h0000_0013

`endif

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // rv32i major opcodes that the core decodes
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASSB
  } alu_op_t;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_t;

  // RES_MEM also marks a load for the hazard unit
  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} result_sel_t;

  // PC_BRANCH only when the branch is taken
  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP} pc_sel_t;

  // source of an E-stage operand
  typedef enum logic [1:0] {FWD_REG, FWD_W, FWD_M} fwd_sel_t;

endpackage

`default_nettype wire

//--- verilog/regfile.sv
`default_nettype none
`include "cpu_settings.svh"

module regfile (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire  [$clog2(`CPU_REG_COUNT)-1:0] rs1,
  input  wire  [$clog2(`CPU_REG_COUNT)-1:0] rs2,
  input  wire  [$clog2(`CPU_REG_COUNT)-1:0] rd,
  input  wire                               we,
  input  wire  [`CPU_XLEN-1:0]              wd,
  output logic [`CPU_XLEN-1:0]              rd1,
  output logic [`CPU_XLEN-1:0]              rd2
);

  logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

  // falling edge write, so a read in D sees the value written from W
  // x0 is cleared in reset and skipped by every write
  always_ff @(negedge clk) begin
    if (!rst_n) begin
      regs[0] <= '0;
    end else if (we && rd != '0) begin
      regs[rd] <= wd;
    end
  end

  assign rd1 = regs[rs1];
  assign rd2 = regs[rs2];

  // a write aimed at x0 must leave it holding zero
  x0_stays_zero: assert property (
    @(negedge clk) disable iff (!rst_n)
    (we && rd == '0) |=> (regs[0] == '0)
  );

endmodule

`default_nettype wire

//--- verilog/datapath.sv
`default_nettype none
`include "cpu_settings.svh"

module datapath (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire  [`CPU_XLEN-1:0]              idt,
  input  wire  cpu_pkg::imm_sel_t           d_imm_sel,
  input  wire  cpu_pkg::alu_op_t            e_alu_op,
  input  wire                               e_alu_src,
  input  wire  cpu_pkg::pc_sel_t            e_pc_sel,
  input  wire                               d_jal,
  input  wire  cpu_pkg::result_sel_t        w_result_sel,
  input  wire                               w_reg_write,
  input  wire  [`CPU_XLEN-1:0]              m_read_data,
  input  wire  cpu_pkg::fwd_sel_t           e_fwd1_sel,
  input  wire  cpu_pkg::fwd_sel_t           e_fwd2_sel,
  input  wire                               f_stall,
  input  wire                               d_stall,
  input  wire                               d_flush,
  input  wire                               e_flush,
  output logic [`CPU_XLEN-1:0]              iad,
  output logic [`CPU_XLEN-1:0]              dad,
  output logic [`CPU_XLEN-1:0]              m_write_data,
  output logic [`CPU_XLEN-1:0]              d_inst,
  output logic                              e_zero,
  output logic                              e_neg,
  output logic [$clog2(`CPU_REG_COUNT)-1:0] d_rs1,
  output logic [$clog2(`CPU_REG_COUNT)-1:0] d_rs2,
  output logic [$clog2(`CPU_REG_COUNT)-1:0] e_rs1,
  output logic [$clog2(`CPU_REG_COUNT)-1:0] e_rs2,
  output logic [$clog2(`CPU_REG_COUNT)-1:0] e_rd,
  output logic [$clog2(`CPU_REG_COUNT)-1:0] m_rd,
  output logic [$clog2(`CPU_REG_COUNT)-1:0] w_rd
);
  import cpu_pkg::*;

  localparam int RW = $clog2(`CPU_REG_COUNT);

  logic [`CPU_XLEN-1:0] f_pc;
  logic [`CPU_XLEN-1:0] d_pc;
  logic [`CPU_XLEN-1:0] d_imm;
  logic [`CPU_XLEN-1:0] d_rd1;
  logic [`CPU_XLEN-1:0] d_rd2;
  logic [RW-1:0]        d_rd;
  logic [`CPU_XLEN-1:0] e_pc;
  logic [`CPU_XLEN-1:0] e_imm;
  logic [`CPU_XLEN-1:0] e_rd1;
  logic [`CPU_XLEN-1:0] e_rd2;
  logic [`CPU_XLEN-1:0] e_a;
  logic [`CPU_XLEN-1:0] e_fwd_b;
  logic [`CPU_XLEN-1:0] e_b;
  logic [`CPU_XLEN-1:0] e_alu_y;
  logic [`CPU_XLEN-1:0] e_result;
  logic [`CPU_XLEN-1:0] m_alu;
  logic [`CPU_XLEN-1:0] w_alu;
  logic [`CPU_XLEN-1:0] w_mem;
  logic [`CPU_XLEN-1:0] w_result;

  function automatic logic [`CPU_XLEN-1:0] fwd_value(
    input fwd_sel_t             sel,
    input logic [`CPU_XLEN-1:0] rf_val,
    input logic [`CPU_XLEN-1:0] m_val,
    input logic [`CPU_XLEN-1:0] w_val
  );
    case (sel)
      FWD_M:   return m_val;
      FWD_W:   return w_val;
      default: return rf_val;
    endcase
  endfunction

  // fetch, a taken branch in E outranks jal in D
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      f_pc <= `CPU_RESET_PC;
    end else if (e_pc_sel == PC_BRANCH) begin
      f_pc <= e_pc + e_imm;
    end else if (d_jal) begin
      f_pc <= d_pc + d_imm;
    end else if (!f_stall) begin
      f_pc <= f_pc + 'd4;
    end
  end

  assign iad = f_pc;

  always_ff @(posedge clk) begin
    if (!rst_n || d_flush) begin
      d_inst <= `CPU_NOP;
    end else if (!d_stall) begin
      d_inst <= idt;
      d_pc   <= f_pc;
    end
  end

  assign d_rs1 = d_inst[19:15];
  assign d_rs2 = d_inst[24:20];
  assign d_rd  = d_inst[11:7];

  // immediate generator
  always_comb begin
    case (d_imm_sel)
      IMM_S:   d_imm = {{(`CPU_XLEN-12){d_inst[31]}}, d_inst[31:25], d_inst[11:7]};
      IMM_B:   d_imm = {{(`CPU_XLEN-12){d_inst[31]}}, d_inst[7], d_inst[30:25],
                        d_inst[11:8], 1'b0};
      IMM_U:   d_imm = {d_inst[31:12], 12'b0};
      IMM_J:   d_imm = {{(`CPU_XLEN-20){d_inst[31]}}, d_inst[19:12], d_inst[20],
                        d_inst[30:21], 1'b0};
      default: d_imm = {{(`CPU_XLEN-12){d_inst[31]}}, d_inst[31:20]};
    endcase
  end

  regfile regfile (
    .clk(clk), .rst_n(rst_n),
    .rs1(d_rs1), .rs2(d_rs2),
    .rd(w_rd), .we(w_reg_write), .wd(w_result),
    .rd1(d_rd1), .rd2(d_rd2)
  );

  always_ff @(posedge clk) begin
    if (!rst_n || e_flush) begin
      e_rs1 <= '0;
      e_rs2 <= '0;
      e_rd  <= '0;
    end else begin
      e_rs1 <= d_rs1;
      e_rs2 <= d_rs2;
      e_rd  <= d_rd;
    end
    e_pc  <= d_pc;
    e_imm <= d_imm;
    e_rd1 <= d_rd1;
    e_rd2 <= d_rd2;
  end

  // operand selection, M has priority over W
  assign e_a     = fwd_value(e_fwd1_sel, e_rd1, m_alu, w_result);
  assign e_fwd_b = fwd_value(e_fwd2_sel, e_rd2, m_alu, w_result);
  assign e_b     = e_alu_src ? e_imm : e_fwd_b;

  // signed compare feeds both slt and blt/bge
  assign e_neg = $signed(e_a) < $signed(e_b);

  always_comb begin
    case (e_alu_op)
      ALU_SUB:   e_alu_y = e_a - e_b;
      ALU_AND:   e_alu_y = e_a & e_b;
      ALU_OR:    e_alu_y = e_a | e_b;
      ALU_XOR:   e_alu_y = e_a ^ e_b;
      ALU_SLT:   e_alu_y = {{(`CPU_XLEN-1){1'b0}}, e_neg};
      ALU_PASSB: e_alu_y = e_b;
      default:   e_alu_y = e_a + e_b;
    endcase
  end

  assign e_zero = (e_alu_y == '0);

  // link value joins the result here, so M forwarding already carries it
  assign e_result = (e_pc_sel == PC_JUMP) ? e_pc + 'd4 : e_alu_y;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_rd <= '0;
    end else begin
      m_rd <= e_rd;
    end
    m_alu        <= e_result;
    m_write_data <= e_fwd_b;
  end

  assign dad = m_alu;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_rd <= '0;
    end else begin
      w_rd <= m_rd;
    end
    w_alu <= m_alu;
    w_mem <= m_read_data;
  end

  // RES_PC4 takes w_alu, which holds pc+4 for jal
  assign w_result = (w_result_sel == RES_MEM) ? w_mem : w_alu;

  iad_aligned: assert property (
    @(posedge clk) disable iff (!rst_n) iad[1:0] == 2'b00
  );

endmodule

`default_nettype wire

//--- verilog/controller.sv
`default_nettype none
`include "cpu_settings.svh"

module controller (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire  [`CPU_XLEN-1:0]        d_inst,
  input  wire                         e_zero,
  input  wire                         e_neg,
  input  wire                         e_flush,
  output logic                        mreq,
  output logic                        write,
  output cpu_pkg::imm_sel_t           d_imm_sel,
  output logic                        d_jal,
  output cpu_pkg::alu_op_t            e_alu_op,
  output logic                        e_alu_src,
  output cpu_pkg::pc_sel_t            e_pc_sel,
  output cpu_pkg::result_sel_t        e_result_sel,
  output logic                        m_reg_write,
  output cpu_pkg::result_sel_t        w_result_sel,
  output logic                        w_reg_write
);
  import cpu_pkg::*;

  opcode_t     opcode;
  logic [2:0]  funct3;
  alu_op_t     d_alu_op;
  logic        d_alu_src;
  result_sel_t d_result_sel;
  logic        d_reg_write;
  logic        d_mem_req;
  logic        d_mem_write;
  logic        d_branch;
  logic        e_reg_write;
  logic        e_mem_req;
  logic        e_mem_write;
  logic        e_branch;
  logic        e_jump;
  logic [2:0]  e_funct3;
  logic        e_taken;
  result_sel_t m_result_sel;

  // shared by register and immediate forms
  function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b010:  return ALU_SLT;
      3'b100:  return ALU_XOR;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return sub ? ALU_SUB : ALU_ADD;
    endcase
  endfunction

  assign opcode = opcode_t'(d_inst[6:0]);
  assign funct3 = d_inst[14:12];

  always_comb begin
    d_imm_sel    = IMM_I;
    d_jal        = 1'b0;
    d_alu_op     = ALU_ADD;
    d_alu_src    = 1'b0;
    d_result_sel = RES_ALU;
    d_reg_write  = 1'b0;
    d_mem_req    = 1'b0;
    d_mem_write  = 1'b0;
    d_branch     = 1'b0;
    case (opcode)
      OP_REG: begin
        d_alu_op    = alu_from_funct3(funct3, d_inst[30]);
        d_reg_write = 1'b1;
      end
      OP_IMM: begin
        d_alu_op    = alu_from_funct3(funct3, 1'b0);
        d_alu_src   = 1'b1;
        d_reg_write = 1'b1;
      end
      OP_LUI: begin
        d_imm_sel   = IMM_U;
        d_alu_op    = ALU_PASSB;
        d_alu_src   = 1'b1;
        d_reg_write = 1'b1;
      end
      OP_LOAD: begin
        d_alu_src    = 1'b1;
        d_result_sel = RES_MEM;
        d_reg_write  = 1'b1;
        d_mem_req    = 1'b1;
      end
      OP_STORE: begin
        d_imm_sel   = IMM_S;
        d_alu_src   = 1'b1;
        d_mem_req   = 1'b1;
        d_mem_write = 1'b1;
      end
      OP_BRANCH: begin
        d_imm_sel = IMM_B;
        d_alu_op  = ALU_SUB;
        d_branch  = 1'b1;
      end
      OP_JAL: begin
        d_imm_sel    = IMM_J;
        d_jal        = 1'b1;
        d_result_sel = RES_PC4;
        d_reg_write  = 1'b1;
      end
      default: ;
    endcase
  end

  // E stage, a flush turns the slot into a bubble
  always_ff @(posedge clk) begin
    if (!rst_n || e_flush) begin
      e_alu_op     <= ALU_ADD;
      e_alu_src    <= 1'b0;
      e_result_sel <= RES_ALU;
      e_reg_write  <= 1'b0;
      e_mem_req    <= 1'b0;
      e_mem_write  <= 1'b0;
      e_branch     <= 1'b0;
      e_jump       <= 1'b0;
    end else begin
      e_alu_op     <= d_alu_op;
      e_alu_src    <= d_alu_src;
      e_result_sel <= d_result_sel;
      e_reg_write  <= d_reg_write;
      e_mem_req    <= d_mem_req;
      e_mem_write  <= d_mem_write;
      e_branch     <= d_branch;
      e_jump       <= d_jal;
    end
    e_funct3 <= funct3;
  end

  // branch condition from the subtract flags
  always_comb begin
    case (e_funct3)
      3'b000:  e_taken = e_zero;
      3'b001:  e_taken = !e_zero;
      3'b100:  e_taken = e_neg;
      3'b101:  e_taken = !e_neg;
      default: e_taken = 1'b0;
    endcase
  end

  // jal already redirected in D, PC_JUMP only marks the link write
  assign e_pc_sel = e_jump ? PC_JUMP : (e_branch && e_taken) ? PC_BRANCH : PC_SEQ;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_reg_write  <= 1'b0;
      m_result_sel <= RES_ALU;
      mreq         <= 1'b0;
      write        <= 1'b0;
      w_reg_write  <= 1'b0;
      w_result_sel <= RES_ALU;
    end else begin
      m_reg_write  <= e_reg_write;
      m_result_sel <= e_result_sel;
      mreq         <= e_mem_req;
      write        <= e_mem_write;
      w_reg_write  <= m_reg_write;
      w_result_sel <= m_result_sel;
    end
  end

  write_has_mreq: assert property (
    @(posedge clk) disable iff (!rst_n) write |-> mreq
  );

endmodule

`default_nettype wire

//--- verilog/hazard.sv
`default_nettype none
`include "cpu_settings.svh"

module hazard (
  input  wire  [$clog2(`CPU_REG_COUNT)-1:0] d_rs1,
  input  wire  [$clog2(`CPU_REG_COUNT)-1:0] d_rs2,
  input  wire  [$clog2(`CPU_REG_COUNT)-1:0] e_rs1,
  input  wire  [$clog2(`CPU_REG_COUNT)-1:0] e_rs2,
  input  wire  [$clog2(`CPU_REG_COUNT)-1:0] e_rd,
  input  wire  [$clog2(`CPU_REG_COUNT)-1:0] m_rd,
  input  wire  [$clog2(`CPU_REG_COUNT)-1:0] w_rd,
  input  wire                               d_jal,
  input  wire  cpu_pkg::pc_sel_t            e_pc_sel,
  input  wire  cpu_pkg::result_sel_t        e_result_sel,
  input  wire                               m_reg_write,
  input  wire                               w_reg_write,
  output cpu_pkg::fwd_sel_t                 e_fwd1_sel,
  output cpu_pkg::fwd_sel_t                 e_fwd2_sel,
  output logic                              f_stall,
  output logic                              d_stall,
  output logic                              d_flush,
  output logic                              e_flush
);
  import cpu_pkg::*;

  localparam int RW = $clog2(`CPU_REG_COUNT);

  logic load_use;
  logic load_stall;
  logic taken;

  // newest writer wins, x0 never forwards
  function automatic fwd_sel_t fwd_for(
    input logic [RW-1:0] src,
    input logic          m_we,
    input logic [RW-1:0] m_dst,
    input logic          w_we,
    input logic [RW-1:0] w_dst
  );
    if (m_we && m_dst != '0 && m_dst == src) return FWD_M;
    if (w_we && w_dst != '0 && w_dst == src) return FWD_W;
    return FWD_REG;
  endfunction

  assign e_fwd1_sel = fwd_for(e_rs1, m_reg_write, m_rd, w_reg_write, w_rd);
  assign e_fwd2_sel = fwd_for(e_rs2, m_reg_write, m_rd, w_reg_write, w_rd);

  assign load_use = (e_result_sel == RES_MEM) && e_rd != '0 &&
                    (e_rd == d_rs1 || e_rd == d_rs2);

  // jal reads no registers, its rs fields are immediate bits
  assign load_stall = load_use && !d_jal;
  assign taken      = (e_pc_sel == PC_BRANCH);

  assign f_stall = load_stall;
  assign d_stall = load_stall;
  assign d_flush = d_jal || taken;
  assign e_flush = load_stall || taken;

  stall_flush_excl: assert final (!(d_stall && d_flush));

endmodule

`default_nettype wire

//--- verilog/top.sv
`default_nettype none
`include "cpu_settings.svh"

module top (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire  [`CPU_XLEN-1:0] idt,
  output logic [`CPU_XLEN-1:0] iad,
  output logic [`CPU_XLEN-1:0] dad,
  output logic                 mreq,
  output logic                 write,
  inout  wire  [`CPU_XLEN-1:0] ddt
);
  import cpu_pkg::*;

  localparam int RW = $clog2(`CPU_REG_COUNT);

  // datapath to controller and hazard
  logic [`CPU_XLEN-1:0] d_inst;
  logic                 e_zero;
  logic                 e_neg;
  logic [RW-1:0]        d_rs1;
  logic [RW-1:0]        d_rs2;
  logic [RW-1:0]        e_rs1;
  logic [RW-1:0]        e_rs2;
  logic [RW-1:0]        e_rd;
  logic [RW-1:0]        m_rd;
  logic [RW-1:0]        w_rd;

  // controller outputs
  imm_sel_t             d_imm_sel;
  logic                 d_jal;
  alu_op_t              e_alu_op;
  logic                 e_alu_src;
  pc_sel_t              e_pc_sel;
  result_sel_t          e_result_sel;
  logic                 m_reg_write;
  result_sel_t          w_result_sel;
  logic                 w_reg_write;

  // hazard outputs
  fwd_sel_t             e_fwd1_sel;
  fwd_sel_t             e_fwd2_sel;
  logic                 f_stall;
  logic                 d_stall;
  logic                 d_flush;
  logic                 e_flush;

  // shared data bus, driven only during a store
  logic [`CPU_XLEN-1:0] m_write_data;
  logic [`CPU_XLEN-1:0] m_read_data;

  assign m_read_data = ddt;
  assign ddt = write ? m_write_data : 'z;

  datapath datapath (
    .clk(clk), .rst_n(rst_n),
    .idt(idt), .m_read_data(m_read_data),
    .d_imm_sel(d_imm_sel), .d_jal(d_jal),
    .e_alu_op(e_alu_op), .e_alu_src(e_alu_src), .e_pc_sel(e_pc_sel),
    .w_result_sel(w_result_sel), .w_reg_write(w_reg_write),
    .e_fwd1_sel(e_fwd1_sel), .e_fwd2_sel(e_fwd2_sel),
    .f_stall(f_stall), .d_stall(d_stall), .d_flush(d_flush), .e_flush(e_flush),
    .iad(iad), .dad(dad), .m_write_data(m_write_data),
    .d_inst(d_inst), .e_zero(e_zero), .e_neg(e_neg),
    .d_rs1(d_rs1), .d_rs2(d_rs2), .e_rs1(e_rs1), .e_rs2(e_rs2),
    .e_rd(e_rd), .m_rd(m_rd), .w_rd(w_rd)
  );

  controller controller (
    .clk(clk), .rst_n(rst_n),
    .d_inst(d_inst), .e_zero(e_zero), .e_neg(e_neg),
    .e_flush(e_flush),
    .mreq(mreq), .write(write),
    .d_imm_sel(d_imm_sel), .d_jal(d_jal),
    .e_alu_op(e_alu_op), .e_alu_src(e_alu_src), .e_pc_sel(e_pc_sel),
    .e_result_sel(e_result_sel), .m_reg_write(m_reg_write),
    .w_result_sel(w_result_sel), .w_reg_write(w_reg_write)
  );

  hazard hazard (
    .d_rs1(d_rs1), .d_rs2(d_rs2), .e_rs1(e_rs1), .e_rs2(e_rs2),
    .e_rd(e_rd), .m_rd(m_rd), .w_rd(w_rd),
    .d_jal(d_jal), .e_pc_sel(e_pc_sel), .e_result_sel(e_result_sel),
    .m_reg_write(m_reg_write), .w_reg_write(w_reg_write),
    .e_fwd1_sel(e_fwd1_sel), .e_fwd2_sel(e_fwd2_sel),
    .f_stall(f_stall), .d_stall(d_stall), .d_flush(d_flush), .e_flush(e_flush)
  );

endmodule

`default_nettype wire

//--- verification/tb_top.sv
`default_nettype none
`include "cpu_settings.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_CYCLES = 8;
  localparam int CASE_WORDS   = 256;
  localparam int IMEM_WORDS   = 128;
  localparam int DMEM_WORDS   = 256;
  localparam int MAX_STORES   = 64;

  logic                 clk;
  logic                 rst_n;
  logic [`CPU_XLEN-1:0] idt;
  wire  [`CPU_XLEN-1:0] iad;
  wire  [`CPU_XLEN-1:0] dad;
  wire                  mreq;
  wire                  write;
  wire  [`CPU_XLEN-1:0] ddt;

  logic [`CPU_XLEN-1:0] case_words [CASE_WORDS];
  logic [`CPU_XLEN-1:0] imem [IMEM_WORDS];
  logic [`CPU_XLEN-1:0] dmem [DMEM_WORDS];
  logic [`CPU_XLEN-1:0] exp_addr [MAX_STORES];
  logic [`CPU_XLEN-1:0] exp_data [MAX_STORES];
  logic [`CPU_XLEN-1:0] prog_bytes;
  logic                 cases_loaded;
  int                   budget;
  int                   prog_len;
  int                   store_count;
  int                   store_idx;

  top dut0 (
    .clk(clk), .rst_n(rst_n),
    .idt(idt), .iad(iad),
    .dad(dad), .mreq(mreq), .write(write), .ddt(ddt)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // instruction memory answers in the same cycle, nop outside the program
  always_comb begin
    if (iad < prog_bytes) begin
      idt = imem[iad[8:2]];
    end else begin
      idt = `CPU_NOP;
    end
  end

  // data memory drives the shared bus only for a load
  assign ddt = (mreq === 1'b1 && write === 1'b0) ? dmem[dad[9:2]] : 'z;

  task automatic check_value(input string what, input logic [`CPU_XLEN-1:0] got,
                             input logic [`CPU_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("error at time %0t: %s got %h expected %h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic verify_reset_outputs();
    check_value("iad during reset", iad, `CPU_RESET_PC);
    check_value("mreq during reset", {31'b0, mreq}, 32'h0);
    check_value("write during reset", {31'b0, write}, 32'h0);
  endtask

  // layout: budget, program length, program, store count, address/data pairs
  task automatic load_cases();
    int base;
    $readmemh("verification/cpu_cases.txt", case_words);
    if ($isunknown(case_words[0]) || $isunknown(case_words[1]) ||
        case_words[1] == 0 || case_words[1] > IMEM_WORDS) begin
      $display("the case file is missing or its header is malformed");
      $display("sim failed");
      $fatal(1);
    end
    budget   = int'(case_words[0]);
    prog_len = int'(case_words[1]);
    for (int i = 0; i < prog_len; i++) begin
      imem[i] = case_words[2 + i];
    end
    base = 2 + prog_len;
    if ($isunknown(case_words[base]) || case_words[base] > MAX_STORES) begin
      $display("the case file has no valid store count after the program");
      $display("sim failed");
      $fatal(1);
    end
    store_count = int'(case_words[base]);
    for (int i = 0; i < store_count; i++) begin
      exp_addr[i] = case_words[base + 1 + 2 * i];
      exp_data[i] = case_words[base + 2 + 2 * i];
    end
    prog_bytes = 32'(4 * prog_len);
  endtask

  // every store on the bus is compared in order, then written to memory
  always @(posedge clk) begin
    if (mreq === 1'b1 && write === 1'b1) begin
      if (store_idx >= store_count) begin
        $display("an extra store to address %h appeared after the last expected one", dad);
        $display("sim failed");
        $fatal(1);
      end
      check_value("store address", dad, exp_addr[store_idx]);
      check_value("store data", ddt, exp_data[store_idx]);
      dmem[dad[9:2]] <= ddt;
      store_idx      <= store_idx + 1;
    end
  end

  initial begin : watchdog
    wait (cases_loaded === 1'b1);
    repeat (RESET_CYCLES + 4 * budget) @(posedge clk);
    $display("timeout, only %0d of %0d stores seen within the cycle budget",
             store_idx, store_count);
    $display("sim failed");
    $fatal(1);
  end

  initial begin : run
    rst_n        = 1'b0;
    cases_loaded = 1'b0;
    store_idx    = 0;
    store_count  = 0;
    budget       = 0;
    prog_bytes   = '0;
    // unwritten words read back as a function of their byte address
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'ha5c3_0000 ^ (32'(i) << 2);
    end
    load_cases();
    cases_loaded = 1'b1;

    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      verify_reset_outputs();
    end
    rst_n = 1'b1;
    // first cycle out of reset fetches address 0, the next fetch follows it
    @(posedge clk);
    #1;
    check_value("fetch after the reset address", iad, `CPU_RESET_PC + 32'd4);

    wait (store_idx == store_count);
    // let the halt loop run so a late extra store is caught
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (store_idx == store_count) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/cpu_cases.txt
// word 0 cycle budget, word 1 program length n, then n program words,
// then the store count and one expected store address and data per line
00000064
00000038
// alu and immediate chains that depend on forwarding from M and W
00500093 00708113 002081b3 40118233
003242b3 10502023 12345337 67836313
0ff37393 0013e433 008374b3 fff4c513
001525b3 ffd0a613 10602223 10a02423
10902623 10b02823 10c02a23
// load-use into an addi and into store data
10402703 00170793 10f02c23 10002803 11002e23
// three pass bne loop summing the counter
00000893 00300913 00000993 00188893 011989b3 ff289ce3 13302023
// blt and bge, each taken once and not taken once
ffe00a13 001a4663 13402223 12102223 001a5663 13402423 0140d463 12102623
0140c463 12102623
// jal link, writes to x0, beq pair, then halt in a self loop
00c00aef 12002823 12002823 13502823 04d00013 00108033 12002a23 00900b13
001b0463 016b0463 13602c23 13602c23 0000006f 00000013 00000013
// expected stores
0000000e
00000100 0000001d
00000104 12345678
00000108 ffffff87
0000010c 00000078
00000110 00000001
00000114 00000000
00000118 12345679
0000011c 0000001d
00000120 00000006
00000128 fffffffe
0000012c 00000005
00000130 000000a8
00000134 00000000
00000138 00000009

//--- top.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/regfile.sv
verilog/datapath.sv
verilog/controller.sv
verilog/hazard.sv
verilog/top.sv
verification/tb_top.sv
